// File: design/gmii_rx_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module gmii_rx_fifo (
    input  logic                              gmii_rx_clk_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0]  gmii_rx_data_i,
    input  logic                              gmii_rx_dv_i,
    input  logic                              gmii_rx_er_i,
    input  logic                              switch_clk,
    input  logic                              switch_rst_n,
    input  logic                              fifo_pop_i,
    output logic [rx_tx_pkg::DATA_WIDTH:0]    fifo_entry_o,  // [8] end tag
    output logic                              fifo_empty_o
);

    logic [1:0] wrst_q;          // reset release into the phy domain
    logic       wrst_n;
    logic       dv_q;
    logic       fault_q;         // sticky per frame, er or dropped byte
    logic       mark_pend_q;     // marker stuck behind a full fifo
    logic       mark_req;
    logic       data_req;
    logic       wr_en;
    logic       w_full;
    logic [rx_tx_pkg::DATA_WIDTH:0] wr_entry;
    logic [rx_tx_pkg::DATA_WIDTH:0] mem [rx_tx_pkg::FIFO_DEPTH];
    logic [rx_tx_pkg::FIFO_AW:0] wbin, wgray, wbin_nxt;
    logic [rx_tx_pkg::FIFO_AW:0] rbin, rgray, rbin_nxt;
    logic [rx_tx_pkg::FIFO_AW:0] rgray_w1, rgray_w2;   // read ptr seen by write side
    logic [rx_tx_pkg::FIFO_AW:0] wgray_r1, wgray_r2;   // write ptr seen by read side

    always_ff @(posedge gmii_rx_clk_i or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            wrst_q <= 2'b00;
        end else begin
            wrst_q <= {wrst_q[0], 1'b1};
        end
    end
    assign wrst_n = wrst_q[1];

    // falling dv closes the frame, marker has priority over data
    assign mark_req = (dv_q && !gmii_rx_dv_i) || mark_pend_q;
    assign data_req = gmii_rx_dv_i && !gmii_rx_er_i && !mark_req;
    assign wr_en    = (mark_req || data_req) && !w_full;
    assign wr_entry = mark_req ? {1'b1, {(rx_tx_pkg::DATA_WIDTH-1){1'b0}}, fault_q}
                               : {1'b0, gmii_rx_data_i};
    assign wbin_nxt = wbin + 1'b1;

    // full when the msbs differ and the rest match (gray)
    assign w_full = (wgray == {~rgray_w2[rx_tx_pkg::FIFO_AW -: 2],
                               rgray_w2[rx_tx_pkg::FIFO_AW-2:0]});

    always_ff @(posedge gmii_rx_clk_i or negedge wrst_n) begin
        if (!wrst_n) begin
            dv_q        <= 1'b0;
            fault_q     <= 1'b0;
            mark_pend_q <= 1'b0;
            wbin        <= '0;
            wgray       <= '0;
            rgray_w1    <= '0;
            rgray_w2    <= '0;
        end else begin
            dv_q     <= gmii_rx_dv_i;
            rgray_w1 <= rgray;
            rgray_w2 <= rgray_w1;
            if (mark_req) begin
                mark_pend_q <= w_full;
                fault_q     <= w_full || gmii_rx_dv_i;  // new frame lost its byte
            end else if (gmii_rx_dv_i && (gmii_rx_er_i || w_full)) begin
                fault_q <= 1'b1;
            end
            if (wr_en) begin
                wbin  <= wbin_nxt;
                wgray <= wbin_nxt ^ (wbin_nxt >> 1);
            end
        end
    end

    always_ff @(posedge gmii_rx_clk_i) begin
        if (wr_en) mem[wbin[rx_tx_pkg::FIFO_AW-1:0]] <= wr_entry;
    end

    // read side, first word fall through
    assign rbin_nxt     = rbin + 1'b1;
    assign fifo_empty_o = (rgray == wgray_r2);
    assign fifo_entry_o = mem[rbin[rx_tx_pkg::FIFO_AW-1:0]];

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            rbin     <= '0;
            rgray    <= '0;
            wgray_r1 <= '0;
            wgray_r2 <= '0;
        end else begin
            wgray_r1 <= wgray;
            wgray_r2 <= wgray_r1;
            if (fifo_pop_i) begin
                rbin  <= rbin_nxt;
                rgray <= rbin_nxt ^ (rbin_nxt >> 1);
            end
        end
    end

    // the parser must never pop an empty fifo
    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        fifo_pop_i |-> !fifo_empty_o);

endmodule

`default_nettype wire

// File: design/rx_addr_capture.sv
`timescale 1ns/10ps
`default_nettype none

module rx_addr_capture (
    input  logic                              switch_clk,
    input  logic                              switch_rst_n,
    input  logic                              addr_shift_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0]  addr_byte_i,
    input  logic [4:0]                        addr_count_i,  // header byte index
    output logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_dst_addr_o,
    output logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_src_addr_o,
    output logic                              mac_addr_valid_o
);

    // first byte on the wire ends up in the top slot
    always_ff @(posedge switch_clk) begin
        if (addr_shift_i) begin
            if (addr_count_i < 5'(rx_tx_pkg::MAC_ADDR_BYTES)) begin
                mac_dst_addr_o <= {mac_dst_addr_o[rx_tx_pkg::MAC_ADDR_BYTES-2:0], addr_byte_i};
            end else if (addr_count_i < 5'(rx_tx_pkg::HEADER_BYTES)) begin
                mac_src_addr_o <= {mac_src_addr_o[rx_tx_pkg::MAC_ADDR_BYTES-2:0], addr_byte_i};
            end
        end
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            mac_addr_valid_o <= 1'b0;
        end else begin
            mac_addr_valid_o <= addr_shift_i &&
                                addr_count_i == 5'(rx_tx_pkg::HEADER_BYTES-1);  // last src byte
        end
    end

endmodule

`default_nettype wire

// File: design/rx_byte_counter.sv
`timescale 1ns/10ps
`default_nettype none

module rx_byte_counter (
    input  logic       switch_clk,
    input  logic       switch_rst_n,
    input  logic       cnt_clear_i,
    input  logic       cnt_incr_i,
    output logic [4:0] count_o
);

    // preamble count first, header count after the sfd clear
    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            count_o <= 5'd0;
        end else if (cnt_clear_i) begin
            count_o <= cnt_incr_i ? 5'd1 : 5'd0;  // clear+incr counts the first byte
        end else if (cnt_incr_i && count_o != 5'(rx_tx_pkg::HEADER_BYTES)) begin
            count_o <= count_o + 5'd1;            // rests at header length
        end
    end

endmodule

`default_nettype wire

// File: design/rx_crc_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rx_crc_checker (
    input  logic                              switch_clk,
    input  logic                              switch_rst_n,
    input  logic                              crc_start_i,
    input  logic                              crc_byte_valid_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0]  crc_byte_i,
    input  logic                              crc_end_i,
    output logic                              crc_fault_o
);

    logic [31:0]                                crc_q;
    logic [3:0][31:0]                           crc_hist;   // [0] newest, crc before each byte
    logic [2:0][rx_tx_pkg::DATA_WIDTH-1:0]      data_hist;  // [0] newest byte
    logic [2:0]                                 seen_q;     // saturates at fcs length
    logic [31:0]                                fcs_exp;
    logic                                       fcs_bad;

    // at end, crc_hist[3] is the crc before fcs byte 0 and data_hist holds bytes 1..3
    assign fcs_exp = ~crc_hist[3];
    // byte 0 checked through the crc it produced, the byte fold is one to one
    assign fcs_bad = ({data_hist[0], data_hist[1], data_hist[2]} != fcs_exp[31:8]) ||
                     (rx_tx_pkg::crc32_next(crc_hist[3], fcs_exp[7:0]) != crc_hist[2]);

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            seen_q      <= 3'd0;
            crc_fault_o <= 1'b0;
        end else begin
            if (crc_start_i) begin
                seen_q <= 3'd0;
            end else if (crc_byte_valid_i && seen_q != 3'(rx_tx_pkg::FCS_BYTES)) begin
                seen_q <= seen_q + 3'd1;
            end
            if (crc_end_i) crc_fault_o <= fcs_bad || (seen_q != 3'(rx_tx_pkg::FCS_BYTES));
        end
    end

    always_ff @(posedge switch_clk) begin
        if (crc_start_i) begin
            crc_q <= rx_tx_pkg::CRC_INIT;
        end else if (crc_byte_valid_i) begin
            crc_q     <= rx_tx_pkg::crc32_next(crc_q, crc_byte_i);
            crc_hist  <= {crc_hist[2:0], crc_q};
            data_hist <= {data_hist[1:0], crc_byte_i};
        end
    end

endmodule

`default_nettype wire

// File: design/rx_frame_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module rx_frame_fsm (
    input  logic                              switch_clk,
    input  logic                              switch_rst_n,
    input  logic [rx_tx_pkg::DATA_WIDTH:0]    fifo_entry_i,
    input  logic                              fifo_empty_i,
    output logic                              fifo_pop_o,
    input  logic [4:0]                        count_i,
    output logic                              cnt_clear_o,
    output logic                              cnt_incr_o,
    output logic                              crc_start_o,
    output logic                              crc_byte_valid_o,
    output logic                              crc_end_o,
    input  logic                              crc_fault_i,
    output logic                              addr_shift_o,
    output logic [rx_tx_pkg::DATA_WIDTH-1:0]  frame_data_o,
    output logic                              frame_valid_o,
    input  logic                              frame_grant_i,
    output logic                              frame_sof_o,
    output logic                              frame_eof_o,
    output logic                              frame_error_o
);

    rx_tx_pkg::rx_state_e state_q, state_d;
    logic                             head_mark;
    logic [rx_tx_pkg::DATA_WIDTH-1:0] head_byte;
    logic can_load;   // output reg empty or draining this cycle
    logic load;
    logic pre_incr;
    logic loaded_q;   // frame_data_o just took a new byte
    logic end_q;
    logic bad_q;
    logic bad_d;

    assign head_mark        = fifo_entry_i[rx_tx_pkg::DATA_WIDTH];
    assign head_byte        = fifo_entry_i[rx_tx_pkg::DATA_WIDTH-1:0];
    assign can_load         = !frame_valid_o || frame_grant_i;
    assign crc_byte_valid_o = loaded_q;
    assign addr_shift_o     = loaded_q && (state_q == rx_tx_pkg::HEADER);
    assign cnt_incr_o       = pre_incr || addr_shift_o;

    always_comb begin
        state_d     = state_q;
        fifo_pop_o  = 1'b0;
        load        = 1'b0;
        pre_incr    = 1'b0;
        cnt_clear_o = 1'b0;
        crc_start_o = 1'b0;
        crc_end_o   = 1'b0;
        bad_d       = 1'b0;
        if (!fifo_empty_i) begin
            case (state_q)
                rx_tx_pkg::IDLE: begin
                    fifo_pop_o = 1'b1;
                    if (!head_mark && head_byte == rx_tx_pkg::PREAMBLE_BYTE) begin
                        cnt_clear_o = 1'b1;
                        pre_incr    = 1'b1;
                        state_d     = rx_tx_pkg::PREAMBLE;
                    end else if (!head_mark) begin
                        state_d = rx_tx_pkg::DISCARD;   // frame without preamble
                    end
                end
                rx_tx_pkg::PREAMBLE: begin
                    fifo_pop_o = 1'b1;
                    if (head_mark) begin
                        state_d = rx_tx_pkg::IDLE;
                    end else if (head_byte == rx_tx_pkg::PREAMBLE_BYTE &&
                                 count_i < 5'(rx_tx_pkg::PREAMBLE_LEN)) begin
                        pre_incr = 1'b1;
                    end else if (head_byte == rx_tx_pkg::SFD_BYTE &&
                                 count_i == 5'(rx_tx_pkg::PREAMBLE_LEN)) begin
                        cnt_clear_o = 1'b1;             // counter now tracks header
                        crc_start_o = 1'b1;
                        state_d     = rx_tx_pkg::HEADER;
                    end else begin
                        state_d = rx_tx_pkg::DISCARD;
                    end
                end
                rx_tx_pkg::HEADER, rx_tx_pkg::PAYLOAD: begin
                    if (!head_mark && can_load) begin
                        fifo_pop_o = 1'b1;
                        load       = 1'b1;
                    end else if (head_mark && !frame_valid_o) begin
                        fifo_pop_o = 1'b1;              // last byte is gone, close frame
                        crc_end_o  = 1'b1;
                        bad_d      = fifo_entry_i[0] || (state_q == rx_tx_pkg::HEADER);
                        state_d    = rx_tx_pkg::IDLE;
                    end
                end
                default: begin
                    fifo_pop_o = 1'b1;                  // drop up to the marker
                    if (head_mark) state_d = rx_tx_pkg::IDLE;
                end
            endcase
        end
        if (addr_shift_o && count_i == 5'(rx_tx_pkg::HEADER_BYTES-1)) begin
            state_d = rx_tx_pkg::PAYLOAD;
        end
    end

    always_ff @(posedge switch_clk or negedge switch_rst_n) begin
        if (!switch_rst_n) begin
            state_q       <= rx_tx_pkg::IDLE;
            loaded_q      <= 1'b0;
            end_q         <= 1'b0;
            bad_q         <= 1'b0;
            frame_valid_o <= 1'b0;
            frame_sof_o   <= 1'b0;
            frame_eof_o   <= 1'b0;
            frame_error_o <= 1'b0;
        end else begin
            state_q       <= state_d;
            loaded_q      <= load;
            end_q         <= crc_end_o;
            bad_q         <= bad_d;
            frame_eof_o   <= end_q;                        // crc_fault_i valid now
            frame_error_o <= end_q && (bad_q || crc_fault_i);
            if (load) begin
                frame_valid_o <= 1'b1;
                frame_sof_o   <= (state_q == rx_tx_pkg::HEADER) && count_i == 5'd0 && !loaded_q;
            end else if (frame_grant_i) begin
                frame_valid_o <= 1'b0;
                frame_sof_o   <= 1'b0;
            end
        end
    end

    always_ff @(posedge switch_clk) begin
        if (load) frame_data_o <= head_byte;
    end

    // memory side sees a stable byte until grant
    assert property (@(posedge switch_clk) disable iff (!switch_rst_n)
        frame_valid_o && !frame_grant_i |=>
            frame_valid_o && $stable(frame_data_o) && $stable(frame_sof_o));

endmodule

`default_nettype wire

// File: design/rx_mac_control.sv
`timescale 1ns/10ps
`default_nettype none

module rx_mac_control (
    input  logic                              gmii_rx_clk_i,
    input  logic [rx_tx_pkg::DATA_WIDTH-1:0]  gmii_rx_data_i,
    input  logic                              gmii_rx_dv_i,
    input  logic                              gmii_rx_er_i,
    input  logic                              switch_clk,
    input  logic                              switch_rst_n,
    output logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_dst_addr_o,
    output logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_src_addr_o,
    output logic                              mac_addr_valid_o,
    output logic [rx_tx_pkg::DATA_WIDTH-1:0]  frame_data_o,
    output logic                              frame_valid_o,
    input  logic                              frame_grant_i,
    output logic                              frame_sof_o,
    output logic                              frame_eof_o,
    output logic                              frame_error_o
);

    logic [rx_tx_pkg::DATA_WIDTH:0] fifo_entry;
    logic       fifo_empty;
    logic       fifo_pop;
    logic [4:0] count;
    logic       cnt_clear;
    logic       cnt_incr;
    logic       crc_start;
    logic       crc_byte_valid;
    logic       crc_end;
    logic       crc_fault;
    logic       addr_shift;

    // phy domain in, switch domain out
    gmii_rx_fifo i_gmii_rx_fifo (
        .gmii_rx_clk_i (gmii_rx_clk_i),
        .gmii_rx_data_i(gmii_rx_data_i),
        .gmii_rx_dv_i  (gmii_rx_dv_i),
        .gmii_rx_er_i  (gmii_rx_er_i),
        .switch_clk    (switch_clk),
        .switch_rst_n  (switch_rst_n),
        .fifo_pop_i    (fifo_pop),
        .fifo_entry_o  (fifo_entry),
        .fifo_empty_o  (fifo_empty)
    );

    rx_frame_fsm i_rx_frame_fsm (
        .switch_clk      (switch_clk),
        .switch_rst_n    (switch_rst_n),
        .fifo_entry_i    (fifo_entry),
        .fifo_empty_i    (fifo_empty),
        .fifo_pop_o      (fifo_pop),
        .count_i         (count),
        .cnt_clear_o     (cnt_clear),
        .cnt_incr_o      (cnt_incr),
        .crc_start_o     (crc_start),
        .crc_byte_valid_o(crc_byte_valid),
        .crc_end_o       (crc_end),
        .crc_fault_i     (crc_fault),
        .addr_shift_o    (addr_shift),
        .frame_data_o    (frame_data_o),
        .frame_valid_o   (frame_valid_o),
        .frame_grant_i   (frame_grant_i),
        .frame_sof_o     (frame_sof_o),
        .frame_eof_o     (frame_eof_o),
        .frame_error_o   (frame_error_o)
    );

    rx_byte_counter i_rx_byte_counter (
        .switch_clk  (switch_clk),
        .switch_rst_n(switch_rst_n),
        .cnt_clear_i (cnt_clear),
        .cnt_incr_i  (cnt_incr),
        .count_o     (count)
    );

    // crc and address capture both read the output byte register
    rx_crc_checker i_rx_crc_checker (
        .switch_clk      (switch_clk),
        .switch_rst_n    (switch_rst_n),
        .crc_start_i     (crc_start),
        .crc_byte_valid_i(crc_byte_valid),
        .crc_byte_i      (frame_data_o),
        .crc_end_i       (crc_end),
        .crc_fault_o     (crc_fault)
    );

    rx_addr_capture i_rx_addr_capture (
        .switch_clk      (switch_clk),
        .switch_rst_n    (switch_rst_n),
        .addr_shift_i    (addr_shift),
        .addr_byte_i     (frame_data_o),
        .addr_count_i    (count),
        .mac_dst_addr_o  (mac_dst_addr_o),
        .mac_src_addr_o  (mac_src_addr_o),
        .mac_addr_valid_o(mac_addr_valid_o)
    );

endmodule

`default_nettype wire

// File: design/rx_tx_pkg.sv
`default_nettype none

package rx_tx_pkg;

    localparam int DATA_WIDTH     = 8;      // gmii is byte wide
    localparam int FIFO_DEPTH     = 16;     // cdc fifo entries
    localparam int FIFO_AW        = 4;      // log2(FIFO_DEPTH)

    localparam logic [DATA_WIDTH-1:0] PREAMBLE_BYTE = 8'h55;
    localparam logic [DATA_WIDTH-1:0] SFD_BYTE      = 8'hD5;

    localparam int PREAMBLE_LEN   = 7;      // 0x55 bytes ahead of the sfd
    localparam int MAC_ADDR_BYTES = 6;
    localparam int HEADER_BYTES   = 12;     // dst + src
    localparam int FCS_BYTES      = 4;

    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320;  // reflected ieee 802.3 poly

    // parser states
    typedef enum logic [2:0] {
        IDLE,
        PREAMBLE,
        HEADER,
        PAYLOAD,
        DISCARD
    } rx_state_e;

    // one byte into the running crc, lsb first
    function automatic logic [31:0] crc32_next(input logic [31:0]           crc,
                                               input logic [DATA_WIDTH-1:0] data);
        logic [31:0] c;
        c = crc ^ {{(32-DATA_WIDTH){1'b0}}, data};
        for (int i = 0; i < DATA_WIDTH; i++) begin
            c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

endpackage

`default_nettype wire

// File: files.f
design/rx_tx_pkg.sv
design/gmii_rx_fifo.sv
design/rx_byte_counter.sv
design/rx_crc_checker.sv
design/rx_addr_capture.sv
design/rx_frame_fsm.sv
design/rx_mac_control.sv
verif/rx_mac_control_tb.sv

// File: verif/rx_mac_control_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rx_mac_control_tb;

    logic                                    switch_clk;
    logic                                    switch_rst_n;
    logic                                    gmii_rx_clk_i;
    logic [rx_tx_pkg::DATA_WIDTH-1:0]        gmii_rx_data_i;
    logic                                    gmii_rx_dv_i;
    logic                                    gmii_rx_er_i;
    logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_dst_addr_o;
    logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] mac_src_addr_o;
    logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] exp_dst;
    logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] exp_src;
    logic                                    mac_addr_valid_o;
    logic [rx_tx_pkg::DATA_WIDTH-1:0]        frame_data_o;
    logic                                    frame_valid_o;
    logic                                    frame_grant_i;
    logic                                    frame_sof_o;
    logic                                    frame_eof_o;
    logic                                    frame_error_o;
    logic [rx_tx_pkg::DATA_WIDTH-1:0]        exp_q[$];   // dst through fcs, wire order
    logic [31:0]                             grant_rnd;
    int                                      seed;
    int                                      grant_mode;  // 0 high, 1 random, 2 low

    rx_mac_control i_rx_mac_control (.*);

    always #4 switch_clk = ~switch_clk;
    always #4.2 gmii_rx_clk_i = ~gmii_rx_clk_i;  // drifts against the switch clock

    always @(posedge switch_clk) begin
        #1;
        grant_rnd = $random(seed);
        case (grant_mode)
            0:       frame_grant_i = 1'b1;
            1:       frame_grant_i = (grant_rnd[2:0] != 3'd0);  // stalls about one cycle in 8
            default: frame_grant_i = 1'b0;
        endcase
    end

    task automatic stop_on_failure();
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [rx_tx_pkg::DATA_WIDTH-1:0] exp,
                              input logic [rx_tx_pkg::DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("ERROR: %s expected %h actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_addr(input string name,
        input logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] exp,
        input logic [rx_tx_pkg::MAC_ADDR_BYTES-1:0][rx_tx_pkg::DATA_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("ERROR: %s expected %h actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERROR: %s expected %h actual %h", name, exp, act);
            stop_on_failure();
        end
    endtask

    // header, random payload, then fcs = ~crc low byte first
    task automatic build_frame(input int pay_len, input bit bad_fcs);
        logic [31:0]                      crc;
        logic [31:0]                      rnd;
        logic [rx_tx_pkg::DATA_WIDTH-1:0] b;
        exp_q.delete();
        for (int i = 0; i < rx_tx_pkg::MAC_ADDR_BYTES; i++)
            exp_q.push_back(exp_dst[rx_tx_pkg::MAC_ADDR_BYTES-1-i]);  // top slot goes first
        for (int i = 0; i < rx_tx_pkg::MAC_ADDR_BYTES; i++)
            exp_q.push_back(exp_src[rx_tx_pkg::MAC_ADDR_BYTES-1-i]);
        for (int i = 0; i < pay_len; i++) begin
            rnd = $random(seed);
            exp_q.push_back(rnd[7:0]);
        end
        crc = rx_tx_pkg::CRC_INIT;
        foreach (exp_q[i]) crc = rx_tx_pkg::crc32_next(crc, exp_q[i]);
        crc = ~crc;
        for (int i = 0; i < rx_tx_pkg::FCS_BYTES; i++) begin
            b = crc[8*i +: 8];
            if (bad_fcs && i == 2) b = ~b;  // corrupt one fcs byte
            exp_q.push_back(b);
        end
    endtask

    task automatic gmii_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge gmii_rx_clk_i);
            #1;
            gmii_rx_dv_i   = 1'b0;
            gmii_rx_er_i   = 1'b0;
            gmii_rx_data_i = '0;
        end
    endtask

    // preamble, sfd, then exp_q; er_idx < 0 means no gmii error
    task automatic drive_frame(input logic [rx_tx_pkg::DATA_WIDTH-1:0] sfd, input int er_idx);
        gmii_idle(12);
        for (int i = 0; i <= rx_tx_pkg::PREAMBLE_LEN; i++) begin
            @(posedge gmii_rx_clk_i);
            #1;
            gmii_rx_dv_i   = 1'b1;
            gmii_rx_data_i = (i == rx_tx_pkg::PREAMBLE_LEN) ? sfd : rx_tx_pkg::PREAMBLE_BYTE;
        end
        foreach (exp_q[i]) begin
            @(posedge gmii_rx_clk_i);
            #1;
            gmii_rx_data_i = exp_q[i];
            gmii_rx_er_i   = (i == er_idx);
        end
        gmii_idle(12);  // falling dv closes the frame
    endtask

    // takes transfers until eof, addresses checked from the valid pulse on
    task automatic collect_frame(input bit cmp_data, output logic err);
        int  n;
        int  wait_cnt;
        bit  addr_seen;
        bit  done;
        n = 0;
        wait_cnt = 0;
        addr_seen = 0;
        done = 0;
        while (!done) begin
            @(posedge switch_clk);
            wait_cnt++;
            if (wait_cnt > 4000) begin
                $display("timeout waiting for end of frame from the DUT");
                stop_on_failure();
            end
            if (mac_addr_valid_o) addr_seen = 1;
            if (addr_seen) begin
                check_addr("mac_dst_addr_o", exp_dst, mac_dst_addr_o);
                check_addr("mac_src_addr_o", exp_src, mac_src_addr_o);
            end
            if (frame_valid_o && frame_grant_i) begin
                check_flag("frame_sof_o", n == 0, frame_sof_o);  // first dst byte only
                if (cmp_data && n >= exp_q.size()) begin
                    $display("DUT sent more bytes than the frame holds");
                    stop_on_failure();
                end
                if (cmp_data) check_byte("frame_data_o", exp_q[n], frame_data_o);
                n++;
            end
            if (frame_eof_o) begin
                check_flag("frame_valid_o", 1'b0, frame_valid_o);
                check_flag("mac_addr_valid_o", 1'b1, addr_seen);
                if (cmp_data && n != exp_q.size()) begin
                    $display("frame ended after %0d bytes instead of %0d", n, exp_q.size());
                    stop_on_failure();
                end
                err  = frame_error_o;
                done = 1;
            end else begin
                check_flag("frame_error_o", 1'b0, frame_error_o);  // only valid with eof
            end
        end
    endtask

    task automatic run_frame(input int er_idx, input bit cmp_data, output logic err);
        fork
            drive_frame(rx_tx_pkg::SFD_BYTE, er_idx);
            collect_frame(cmp_data, err);
        join
    endtask

    task automatic check_reset_state();
        @(posedge switch_clk);
        check_flag("frame_valid_o", 1'b0, frame_valid_o);
        check_flag("frame_sof_o", 1'b0, frame_sof_o);
        check_flag("frame_eof_o", 1'b0, frame_eof_o);
        check_flag("frame_error_o", 1'b0, frame_error_o);
        check_flag("mac_addr_valid_o", 1'b0, mac_addr_valid_o);
    endtask

    task automatic test_good_frame();
        logic err;
        exp_dst = 48'h01_00_5E_10_20_30;
        exp_src = 48'h02_AA_BB_CC_DD_EE;
        build_frame(48, 1'b0);  // 64 bytes with header and fcs
        run_frame(-1, 1'b1, err);
        check_flag("frame_error_o", 1'b0, err);
    endtask

    task automatic test_bad_fcs();
        logic err;
        build_frame(40, 1'b1);
        run_frame(-1, 1'b1, err);
        check_flag("frame_error_o", 1'b1, err);
    endtask

    task automatic test_gmii_error();
        logic err;
        exp_src = 48'h02_12_34_56_78_9A;
        build_frame(40, 1'b0);
        run_frame(30, 1'b0, err);  // er on a payload byte, that byte is lost
        check_flag("frame_error_o", 1'b1, err);
        build_frame(46, 1'b0);
        run_frame(-1, 1'b1, err);
        check_flag("frame_error_o", 1'b0, err);
    endtask

    task automatic test_bad_sfd();
        logic err;
        build_frame(40, 1'b0);
        // the discarded frame must add nothing ahead of the good one
        fork
            begin
                drive_frame(8'hD4, -1);
                drive_frame(rx_tx_pkg::SFD_BYTE, -1);
            end
            collect_frame(1'b1, err);
        join
        check_flag("frame_error_o", 1'b0, err);
    endtask

    task automatic test_backpressure();
        logic err;
        grant_mode = 1;
        build_frame(20, 1'b0);  // short enough that the stalls fit in the fifo
        run_frame(-1, 1'b1, err);
        check_flag("frame_error_o", 1'b0, err);
        grant_mode = 2;  // fifo fills while the whole frame arrives
        build_frame(64, 1'b0);
        drive_frame(rx_tx_pkg::SFD_BYTE, -1);
        grant_mode = 0;
        collect_frame(1'b0, err);
        check_flag("frame_error_o", 1'b1, err);
    endtask

    initial begin
        seed           = 8210;
        grant_mode     = 0;
        switch_clk     = 1'b0;
        gmii_rx_clk_i  = 1'b0;
        switch_rst_n   = 1'b0;
        gmii_rx_data_i = '0;
        gmii_rx_dv_i   = 1'b0;
        gmii_rx_er_i   = 1'b0;
        frame_grant_i  = 1'b1;
        repeat (5) @(posedge switch_clk);
        #1;
        switch_rst_n = 1'b1;
        check_reset_state();
        test_good_frame();
        test_bad_fcs();
        test_gmii_error();
        test_bad_sfd();
        test_backpressure();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
